// File: hw/cc_config.svh
/* Coherence controller configuration
   Cache sizes, field widths and APB address layout */

`ifndef CC_CONFIG_SVH
`define CC_CONFIG_SVH

// Cache geometry
`define CC_NUM_LINES 4
`define CC_LINE_W    2
`define CC_DATA_W    32

// Network fields
`define CC_ACK_W     4   // Ack count and balance
`define CC_NODE_W    4   // Node id

// APB address map
`define CC_ADDR_W    8
`define CC_LINE_LSB  2   // Line index in paddr[3:2]
`define CC_EVICT_BIT 4   // Write here means replacement

`endif

// File: hw/cc_pkg.sv
/* Coherence controller types
   Line states, table events, message encodings and the table entry */

`include "cc_config.svh"

package cc_pkg;

	// Stable and transient MSI states
	typedef enum logic [3:0] {
		I, ISd, IMad, IMa,
		S, SMad, SMa,
		M, MIa, SIa, IIa
	} state_t;

	// Table input, after the network decode
	typedef enum logic [3:0] {
		load, store, replacement,
		inv, fwd_gets, fwd_getm, put_ack,
		data_dir_eqz, data_dir_gtz, data_owner,
		inv_ack, last_inv_ack
	} event_t;

	// From the directory side
	typedef enum logic [2:0] {
		INV, FWD_GETS, FWD_GETM, PUT_ACK,
		DATA_DIR, DATA_OWNER, INV_ACK
	} in_msg_t;

	// Requests and responses we send
	typedef enum logic [2:0] {
		GETS, GETM, PUTS, PUTM, INV_ACK_RSP, DATA_RSP
	} out_msg_t;

	typedef enum logic [1:0] {
		NONE,   // No payload
		LINE,   // Current line contents
		MSHR    // Eviction buffer
	} data_src_t;

	// Inbound aux word, meaning depends on in_type
	typedef union packed {
		logic [`CC_ACK_W-1:0]  ack_count;   // DATA_DIR
		logic [`CC_NODE_W-1:0] requestor;   // Fwd_GetS, Fwd_GetM, Inv
	} msg_aux_u;

	// One protocol table output
	typedef struct packed {
		logic      stall;
		logic      core_done;         // APB access finishes
		state_t    next_state;
		logic      send;
		out_msg_t  msg;
		logic      dest_dir;
		logic      dest_req;
		data_src_t data_src;
		logic      write_line;
		logic      write_from_net;    // Else from pwdata
		logic      alloc_mshr;
		logic      dealloc_mshr;
		logic      save_evict_data;
		logic      load_acks;
		logic      dec_acks;
		logic      not_admitted;      // No table entry
	} rom_entry_t;

endpackage

// File: hw/cc_ctrl_if.sv
/* Table control bundle
   Actions of the fired event, fanned out to the data modules */

`timescale 1ns/10ps
`include "cc_config.svh"

interface cc_ctrl_if;
	logic                  ev_valid;        // Event fired this cycle
	logic [`CC_LINE_W-1:0] ev_line;
	logic                  write_line;
	logic                  write_from_net;
	logic                  save_evict_data;
	logic                  send;
	cc_pkg::out_msg_t      msg_type;
	logic                  dest_dir;
	logic                  dest_req;
	cc_pkg::data_src_t     data_src;
	logic                  load_acks;
	logic                  dec_acks;

	modport table_side (
		output ev_valid, ev_line, write_line, write_from_net, save_evict_data,
		output send, msg_type, dest_dir, dest_req, data_src, load_acks, dec_acks
	);
	modport acks_side (input load_acks, dec_acks);
	modport data_side (input ev_valid, ev_line, write_line, write_from_net, save_evict_data);
	modport msg_side (input ev_line, send, msg_type, dest_dir, dest_req, data_src);
endinterface

// File: hw/cc_protocol_fsm.sv
/* MSI protocol FSM
   Picks one event per cycle, looks it up in the protocol table and
   keeps the per-line states, the single MSHR and the APB ready */

`timescale 1ns/10ps
`include "cc_config.svh"

module cc_protocol_fsm (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`CC_ADDR_W-1:0] paddr,
	input  logic                  in_valid,
	input  cc_pkg::in_msg_t       in_type,
	input  logic [`CC_LINE_W-1:0] in_line,
	input  cc_pkg::msg_aux_u      in_aux,
	input  logic                  ack_last,
	input  logic                  acks_covered,
	input  logic                  out_busy,
	output logic                  in_ready,
	output logic                  pready,
	cc_ctrl_if.table_side         ctrl
);

	cc_pkg::state_t        state_q [`CC_NUM_LINES];
	cc_pkg::state_t        cur_state;
	cc_pkg::event_t        core_ev;
	cc_pkg::event_t        net_ev;
	cc_pkg::event_t        cur_ev;
	cc_pkg::rom_entry_t    entry;
	logic                  core_req;
	logic [`CC_LINE_W-1:0] core_line;
	logic [`CC_LINE_W-1:0] ev_line;
	logic                  mshr_busy;
	logic [`CC_LINE_W-1:0] mshr_line;
	logic                  mshr_stall;
	logic                  fire;

	// -------------------------------------------------------------------
	// Event selection
	// -------------------------------------------------------------------

	assign core_req  = psel & penable & ~pready;   // Access phase, not yet done
	assign core_line = paddr[`CC_LINE_LSB +: `CC_LINE_W];

	always_comb begin
		if (!pwrite)
			core_ev = cc_pkg::load;
		else if (paddr[`CC_EVICT_BIT])
			core_ev = cc_pkg::replacement;   // Evict window
		else
			core_ev = cc_pkg::store;
	end

	always_comb begin
		case (in_type)
			cc_pkg::INV:        net_ev = cc_pkg::inv;
			cc_pkg::FWD_GETS:   net_ev = cc_pkg::fwd_gets;
			cc_pkg::FWD_GETM:   net_ev = cc_pkg::fwd_getm;
			cc_pkg::PUT_ACK:    net_ev = cc_pkg::put_ack;
			cc_pkg::DATA_OWNER: net_ev = cc_pkg::data_owner;
			// Acks already in count as ack zero, so no IMd
			cc_pkg::DATA_DIR:
				net_ev = (in_aux.ack_count == '0 || acks_covered) ?
					cc_pkg::data_dir_eqz : cc_pkg::data_dir_gtz;
			cc_pkg::INV_ACK:
				net_ev = ack_last ? cc_pkg::last_inv_ack : cc_pkg::inv_ack;
			default:            net_ev = cc_pkg::inv;
		endcase
	end

	// Network first
	assign cur_ev    = in_valid ? net_ev : core_ev;
	assign ev_line   = in_valid ? in_line : core_line;
	assign cur_state = state_q[ev_line];

	// -------------------------------------------------------------------
	// Protocol table
	// -------------------------------------------------------------------

	always_comb begin
		entry            = '0;
		entry.next_state = cur_state;   // Default hold
		case ({cur_state, cur_ev})
			{cc_pkg::I, cc_pkg::load}: begin
				entry.send       = 1'b1;   // GetS to directory
				entry.msg        = cc_pkg::GETS;
				entry.dest_dir   = 1'b1;
				entry.alloc_mshr = 1'b1;
				entry.next_state = cc_pkg::ISd;
			end
			{cc_pkg::I, cc_pkg::store}, {cc_pkg::S, cc_pkg::store}: begin
				entry.send       = 1'b1;   // GetM, also the upgrade
				entry.msg        = cc_pkg::GETM;
				entry.dest_dir   = 1'b1;
				entry.alloc_mshr = 1'b1;
				entry.next_state = (cur_state == cc_pkg::I) ? cc_pkg::IMad : cc_pkg::SMad;
			end
			{cc_pkg::I, cc_pkg::replacement}: begin
				entry.core_done = 1'b1;   // Nothing to give back
			end
			{cc_pkg::ISd, cc_pkg::data_dir_eqz}, {cc_pkg::ISd, cc_pkg::data_dir_gtz},
			{cc_pkg::ISd, cc_pkg::data_owner}: begin
				entry.write_line     = 1'b1;
				entry.write_from_net = 1'b1;
				entry.dealloc_mshr   = 1'b1;
				entry.next_state     = cc_pkg::S;
			end
			{cc_pkg::IMad, cc_pkg::data_dir_eqz}, {cc_pkg::IMad, cc_pkg::data_owner}: begin
				entry.write_line     = 1'b1;
				entry.write_from_net = 1'b1;
				entry.load_acks      = (cur_ev == cc_pkg::data_dir_eqz);   // Settle balance
				entry.dealloc_mshr   = 1'b1;
				entry.next_state     = cc_pkg::M;
			end
			{cc_pkg::IMad, cc_pkg::data_dir_gtz}: begin
				entry.write_line     = 1'b1;   // Data now, acks later
				entry.write_from_net = 1'b1;
				entry.load_acks      = 1'b1;
				entry.next_state     = cc_pkg::IMa;
			end
			{cc_pkg::IMad, cc_pkg::inv_ack}, {cc_pkg::IMa, cc_pkg::inv_ack},
			{cc_pkg::SMad, cc_pkg::inv_ack}, {cc_pkg::SMa, cc_pkg::inv_ack}: begin
				entry.dec_acks = 1'b1;
			end
			{cc_pkg::IMa, cc_pkg::last_inv_ack}, {cc_pkg::SMa, cc_pkg::last_inv_ack}: begin
				entry.dec_acks     = 1'b1;
				entry.dealloc_mshr = 1'b1;
				entry.next_state   = cc_pkg::M;
			end
			// Read hits, SMad and SMa still hold valid data
			{cc_pkg::S, cc_pkg::load}, {cc_pkg::SMad, cc_pkg::load},
			{cc_pkg::SMa, cc_pkg::load}, {cc_pkg::M, cc_pkg::load}: begin
				entry.core_done = 1'b1;
			end
			{cc_pkg::S, cc_pkg::replacement}: begin
				entry.send       = 1'b1;
				entry.msg        = cc_pkg::PUTS;
				entry.dest_dir   = 1'b1;
				entry.alloc_mshr = 1'b1;
				entry.core_done  = 1'b1;   // Done once PutS leaves
				entry.next_state = cc_pkg::SIa;
			end
			{cc_pkg::S, cc_pkg::inv}, {cc_pkg::SIa, cc_pkg::inv}: begin
				entry.send       = 1'b1;
				entry.msg        = cc_pkg::INV_ACK_RSP;
				entry.dest_req   = 1'b1;
				entry.next_state = (cur_state == cc_pkg::S) ? cc_pkg::I : cc_pkg::IIa;
			end
			{cc_pkg::SMad, cc_pkg::inv}, {cc_pkg::SMa, cc_pkg::inv}: begin
				entry.send       = 1'b1;   // Lost the copy, still waiting on GetM
				entry.msg        = cc_pkg::INV_ACK_RSP;
				entry.dest_req   = 1'b1;
				entry.next_state = (cur_state == cc_pkg::SMad) ? cc_pkg::IMad : cc_pkg::IMa;
			end
			{cc_pkg::SMad, cc_pkg::data_dir_eqz}, {cc_pkg::SMad, cc_pkg::data_owner}: begin
				entry.load_acks    = (cur_ev == cc_pkg::data_dir_eqz);
				entry.dealloc_mshr = 1'b1;
				entry.next_state   = cc_pkg::M;
			end
			{cc_pkg::SMad, cc_pkg::data_dir_gtz}: begin
				entry.load_acks  = 1'b1;
				entry.next_state = cc_pkg::SMa;
			end
			{cc_pkg::M, cc_pkg::store}: begin
				entry.core_done  = 1'b1;   // Write hit
				entry.write_line = 1'b1;
			end
			{cc_pkg::M, cc_pkg::replacement}: begin
				entry.send            = 1'b1;
				entry.msg             = cc_pkg::PUTM;
				entry.dest_dir        = 1'b1;
				entry.data_src        = cc_pkg::LINE;
				entry.save_evict_data = 1'b1;   // Kept for MIa forwards
				entry.alloc_mshr      = 1'b1;
				entry.core_done       = 1'b1;
				entry.next_state      = cc_pkg::MIa;
			end
			{cc_pkg::M, cc_pkg::fwd_gets}, {cc_pkg::MIa, cc_pkg::fwd_gets}: begin
				entry.send       = 1'b1;   // Data to dir and requestor
				entry.msg        = cc_pkg::DATA_RSP;
				entry.dest_dir   = 1'b1;
				entry.dest_req   = 1'b1;
				entry.data_src   = (cur_state == cc_pkg::M) ? cc_pkg::LINE : cc_pkg::MSHR;
				entry.next_state = (cur_state == cc_pkg::M) ? cc_pkg::S : cc_pkg::SIa;
			end
			{cc_pkg::M, cc_pkg::fwd_getm}, {cc_pkg::MIa, cc_pkg::fwd_getm}: begin
				entry.send       = 1'b1;   // Data to requestor only
				entry.msg        = cc_pkg::DATA_RSP;
				entry.dest_req   = 1'b1;
				entry.data_src   = (cur_state == cc_pkg::M) ? cc_pkg::LINE : cc_pkg::MSHR;
				entry.next_state = (cur_state == cc_pkg::M) ? cc_pkg::I : cc_pkg::IIa;
			end
			{cc_pkg::MIa, cc_pkg::put_ack}, {cc_pkg::SIa, cc_pkg::put_ack},
			{cc_pkg::IIa, cc_pkg::put_ack}: begin
				entry.dealloc_mshr = 1'b1;
				entry.next_state   = cc_pkg::I;
			end
			// Transient lines hold the request
			{cc_pkg::ISd, cc_pkg::load}, {cc_pkg::ISd, cc_pkg::store},
			{cc_pkg::ISd, cc_pkg::replacement}, {cc_pkg::ISd, cc_pkg::inv},
			{cc_pkg::IMad, cc_pkg::load}, {cc_pkg::IMad, cc_pkg::store},
			{cc_pkg::IMad, cc_pkg::replacement}, {cc_pkg::IMad, cc_pkg::fwd_gets},
			{cc_pkg::IMad, cc_pkg::fwd_getm}, {cc_pkg::IMa, cc_pkg::load},
			{cc_pkg::IMa, cc_pkg::store}, {cc_pkg::IMa, cc_pkg::replacement},
			{cc_pkg::IMa, cc_pkg::fwd_gets}, {cc_pkg::IMa, cc_pkg::fwd_getm},
			{cc_pkg::SMad, cc_pkg::store}, {cc_pkg::SMad, cc_pkg::replacement},
			{cc_pkg::SMad, cc_pkg::fwd_gets}, {cc_pkg::SMad, cc_pkg::fwd_getm},
			{cc_pkg::SMa, cc_pkg::store}, {cc_pkg::SMa, cc_pkg::replacement},
			{cc_pkg::SMa, cc_pkg::fwd_gets}, {cc_pkg::SMa, cc_pkg::fwd_getm},
			{cc_pkg::MIa, cc_pkg::load}, {cc_pkg::MIa, cc_pkg::store},
			{cc_pkg::MIa, cc_pkg::replacement}, {cc_pkg::SIa, cc_pkg::load},
			{cc_pkg::SIa, cc_pkg::store}, {cc_pkg::SIa, cc_pkg::replacement},
			{cc_pkg::IIa, cc_pkg::load}, {cc_pkg::IIa, cc_pkg::store},
			{cc_pkg::IIa, cc_pkg::replacement}: begin
				entry.stall = 1'b1;
			end
			default: begin
				entry.not_admitted = 1'b1;   // No actions, state kept
			end
		endcase
	end

	// -------------------------------------------------------------------
	// Fire and state update
	// -------------------------------------------------------------------

	// Single MSHR, a second miss waits
	assign mshr_stall = entry.alloc_mshr & mshr_busy & (mshr_line != ev_line);
	assign fire = (in_valid | core_req) & ~entry.stall & ~mshr_stall
		& ~(entry.send & out_busy);
	assign in_ready = in_valid & fire;

	assign ctrl.ev_valid        = fire;
	assign ctrl.ev_line         = ev_line;
	assign ctrl.write_line      = fire & entry.write_line;
	assign ctrl.write_from_net  = entry.write_from_net;
	assign ctrl.save_evict_data = fire & entry.save_evict_data;
	assign ctrl.send            = fire & entry.send;
	assign ctrl.msg_type        = entry.msg;
	assign ctrl.dest_dir        = entry.dest_dir;
	assign ctrl.dest_req        = entry.dest_req;
	assign ctrl.data_src        = entry.data_src;
	assign ctrl.load_acks       = fire & entry.load_acks;
	assign ctrl.dec_acks        = fire & entry.dec_acks;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CC_NUM_LINES; i++)
				state_q[i] <= cc_pkg::I;
			mshr_busy <= 1'b0;
			pready    <= 1'b0;
		end else begin
			pready <= fire & entry.core_done;   // One cycle, core events only
			if (fire)
				state_q[ev_line] <= entry.next_state;
			if (fire & entry.alloc_mshr)
				mshr_busy <= 1'b1;
			else if (fire & entry.dealloc_mshr)
				mshr_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire & entry.alloc_mshr)
			mshr_line <= ev_line;
	end

endmodule

// File: hw/cc_ack_counter.sv
/* Invalidation ack counter
   Signed balance of the outstanding store miss; negative while acks
   run ahead of the directory data */

`timescale 1ns/10ps
`include "cc_config.svh"

module cc_ack_counter (
	input  logic             clk,
	input  logic             rst,
	cc_ctrl_if.acks_side     ctrl,
	input  cc_pkg::msg_aux_u in_aux,
	output logic             ack_last,
	output logic             acks_covered
);

	localparam logic signed [`CC_ACK_W-1:0] ONE = 1;

	logic signed [`CC_ACK_W-1:0] balance_q;
	logic signed [`CC_ACK_W-1:0] ack_count;
	logic signed [`CC_ACK_W-1:0] cover_sum;

	assign ack_count = $signed(in_aux.ack_count);
	assign cover_sum = ack_count + balance_q;

	assign ack_last     = (balance_q == ONE);   // Next Inv_Ack closes it
	assign acks_covered = (cover_sum == '0);    // All acks already here

	always_ff @(posedge clk) begin
		if (rst)
			balance_q <= '0;
		else if (ctrl.load_acks)
			balance_q <= cover_sum;   // Add the directory count
		else if (ctrl.dec_acks)
			balance_q <= balance_q - ONE;
	end

endmodule

// File: hw/cc_line_store.sv
/* Line data store
   One word per line, APB read register and the eviction buffer */

`timescale 1ns/10ps
`include "cc_config.svh"

module cc_line_store (
	input  logic                  clk,
	input  logic                  rst,
	cc_ctrl_if.data_side          ctrl,
	input  logic [`CC_DATA_W-1:0] pwdata,
	input  logic [`CC_DATA_W-1:0] in_data,
	output logic [`CC_DATA_W-1:0] prdata,
	output logic [`CC_DATA_W-1:0] line_data,
	output logic [`CC_DATA_W-1:0] evict_data
);

	logic [`CC_DATA_W-1:0] mem [`CC_NUM_LINES];

	assign line_data = mem[ctrl.ev_line];   // Old value during a write

	// Store hit or fill
	always_ff @(posedge clk) begin
		if (ctrl.write_line)
			mem[ctrl.ev_line] <= ctrl.write_from_net ? in_data : pwdata;
	end

	// Captured on every event
	// Valid to the core only in the pready cycle
	always_ff @(posedge clk) begin
		if (rst)
			prdata <= '0;
		else if (ctrl.ev_valid)
			prdata <= line_data;
	end

	// Copy for PutM and forwards in MIa
	always_ff @(posedge clk) begin
		if (ctrl.save_evict_data)
			evict_data <= line_data;
	end

endmodule

// File: hw/cc_msg_out.sv
/* Outbound message register
   One slot, filled on send and held until the network takes it */

`timescale 1ns/10ps
`include "cc_config.svh"

module cc_msg_out (
	input  logic                  clk,
	input  logic                  rst,
	cc_ctrl_if.msg_side           ctrl,
	input  cc_pkg::msg_aux_u      in_aux,
	input  logic [`CC_DATA_W-1:0] line_data,
	input  logic [`CC_DATA_W-1:0] evict_data,
	input  logic                  out_ready,
	output logic                  out_busy,
	output logic                  out_valid,
	output cc_pkg::out_msg_t      out_type,
	output logic [`CC_LINE_W-1:0] out_line,
	output logic                  out_dest_dir,
	output logic                  out_dest_req,
	output logic [`CC_NODE_W-1:0] out_node,
	output logic [`CC_DATA_W-1:0] out_data
);

	logic [`CC_DATA_W-1:0] send_data;

	always_comb begin
		case (ctrl.data_src)
			cc_pkg::LINE: send_data = line_data;
			cc_pkg::MSHR: send_data = evict_data;   // Line already given up
			default:      send_data = '0;
		endcase
	end

	assign out_busy = out_valid & ~out_ready;   // Slot frees this cycle otherwise

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (ctrl.send)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// Payload, stable while out_valid
	always_ff @(posedge clk) begin
		if (ctrl.send) begin
			out_type     <= ctrl.msg_type;
			out_line     <= ctrl.ev_line;
			out_dest_dir <= ctrl.dest_dir;
			out_dest_req <= ctrl.dest_req;
			out_node     <= ctrl.dest_req ? in_aux.requestor : '0;
			out_data     <= send_data;
		end
	end

endmodule

// File: hw/cc_top.sv
/* Coherence controller top
   APB core port, directory network ports and the submodules */

`timescale 1ns/10ps
`include "cc_config.svh"

module cc_top (
	input  logic                  clk,
	input  logic                  rst,
	// APB slave
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`CC_ADDR_W-1:0] paddr,
	input  logic [`CC_DATA_W-1:0] pwdata,
	output logic [`CC_DATA_W-1:0] prdata,
	output logic                  pready,
	// From directory
	input  logic                  in_valid,
	output logic                  in_ready,
	input  cc_pkg::in_msg_t       in_type,
	input  logic [`CC_LINE_W-1:0] in_line,
	input  cc_pkg::msg_aux_u      in_aux,
	input  logic [`CC_DATA_W-1:0] in_data,
	// To directory or requestor
	output logic                  out_valid,
	input  logic                  out_ready,
	output cc_pkg::out_msg_t      out_type,
	output logic [`CC_LINE_W-1:0] out_line,
	output logic                  out_dest_dir,
	output logic                  out_dest_req,
	output logic [`CC_NODE_W-1:0] out_node,
	output logic [`CC_DATA_W-1:0] out_data
);

	logic                  ack_last;
	logic                  acks_covered;
	logic                  out_busy;
	logic [`CC_DATA_W-1:0] line_data;
	logic [`CC_DATA_W-1:0] evict_data;

	cc_ctrl_if ctrl ();

	cc_protocol_fsm i_fsm (
		.clk          (clk),
		.rst          (rst),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.in_valid     (in_valid),
		.in_type      (in_type),
		.in_line      (in_line),
		.in_aux       (in_aux),
		.ack_last     (ack_last),
		.acks_covered (acks_covered),
		.out_busy     (out_busy),
		.in_ready     (in_ready),
		.pready       (pready),
		.ctrl         (ctrl.table_side)
	);

	cc_ack_counter i_acks (
		.clk          (clk),
		.rst          (rst),
		.ctrl         (ctrl.acks_side),
		.in_aux       (in_aux),
		.ack_last     (ack_last),
		.acks_covered (acks_covered)
	);

	cc_line_store i_store (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrl.data_side),
		.pwdata     (pwdata),
		.in_data    (in_data),
		.prdata     (prdata),
		.line_data  (line_data),
		.evict_data (evict_data)
	);

	cc_msg_out i_msg (
		.clk          (clk),
		.rst          (rst),
		.ctrl         (ctrl.msg_side),
		.in_aux       (in_aux),
		.line_data    (line_data),
		.evict_data   (evict_data),
		.out_ready    (out_ready),
		.out_busy     (out_busy),
		.out_valid    (out_valid),
		.out_type     (out_type),
		.out_line     (out_line),
		.out_dest_dir (out_dest_dir),
		.out_dest_req (out_dest_req),
		.out_node     (out_node),
		.out_data     (out_data)
	);

endmodule

// File: verif/cc_asserts.sv
/* Protocol assertions
   Outbound slot stability, APB ready timing and table coverage */

`timescale 1ns/10ps
`include "cc_config.svh"

module cc_asserts (
	input logic                  clk,
	input logic                  rst,
	input logic                  psel,
	input logic                  penable,
	input logic                  pready,
	input logic                  out_valid,
	input logic                  out_ready,
	input cc_pkg::out_msg_t      out_type,
	input logic [`CC_LINE_W-1:0] out_line,
	input logic                  out_dest_dir,
	input logic                  out_dest_req,
	input logic [`CC_NODE_W-1:0] out_node,
	input logic [`CC_DATA_W-1:0] out_data,
	input logic                  bad_fire      // Fired without a table entry
);

	int unsigned fail_count = 0;   // Read by the testbench

	// Message held until the network takes it
	out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid
			&& $stable({out_type, out_line, out_dest_dir, out_dest_req, out_node, out_data}))
		else begin
			$error("outbound message changed or dropped before out_ready");
			fail_count++;
		end

	ready_in_access: assert property (@(posedge clk) disable iff (rst)
		pready |-> psel && penable)
		else begin
			$error("pready high outside an APB access phase");
			fail_count++;
		end

	admitted: assert property (@(posedge clk) disable iff (rst) !bad_fire)
		else begin
			$error("event fired with no protocol table entry");
			fail_count++;
		end

endmodule

bind cc_top cc_asserts i_asserts (
	.clk          (clk),
	.rst          (rst),
	.psel         (psel),
	.penable      (penable),
	.pready       (pready),
	.out_valid    (out_valid),
	.out_ready    (out_ready),
	.out_type     (out_type),
	.out_line     (out_line),
	.out_dest_dir (out_dest_dir),
	.out_dest_req (out_dest_req),
	.out_node     (out_node),
	.out_data     (out_data),
	.bad_fire     (i_fsm.fire & i_fsm.entry.not_admitted)
);

// File: verif/cc_tb.sv
/* Coherence controller testbench
   Plays the CPU on APB and the directory on the network ports
   Operations and expected values come from the test data file */

`timescale 1ns/10ps
`include "cc_config.svh"

module cc_tb;

	localparam int DRIVE_DLY = 2;     // After the rising edge
	localparam int OP_NS     = 200;   // Watchdog budget per operation

	// One parsed line of test data
	typedef struct packed {
		logic [7:0]  op;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [31:0] f5;
	} op_rec_t;

	logic                  clk;
	logic                  rst;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [`CC_ADDR_W-1:0] paddr;
	logic [`CC_DATA_W-1:0] pwdata;
	logic [`CC_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  in_valid;
	logic                  in_ready;
	cc_pkg::in_msg_t       in_type;
	logic [`CC_LINE_W-1:0] in_line;
	cc_pkg::msg_aux_u      in_aux;
	logic [`CC_DATA_W-1:0] in_data;
	logic                  out_valid;
	logic                  out_ready;
	cc_pkg::out_msg_t      out_type;
	logic [`CC_LINE_W-1:0] out_line;
	logic                  out_dest_dir;
	logic                  out_dest_req;
	logic [`CC_NODE_W-1:0] out_node;
	logic [`CC_DATA_W-1:0] out_data;

	op_rec_t               ops [$];
	logic                  apb_busy;        // Background transfer running
	logic [`CC_DATA_W-1:0] apb_rdata;       // prdata at pready
	int unsigned           watchdog_ns = 0;

	cc_top i_dut (
		.clk          (clk),
		.rst          (rst),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_type      (in_type),
		.in_line      (in_line),
		.in_aux       (in_aux),
		.in_data      (in_data),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_type     (out_type),
		.out_line     (out_line),
		.out_dest_dir (out_dest_dir),
		.out_dest_req (out_dest_req),
		.out_node     (out_node),
		.out_data     (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	// ---------------------------------------------------------------------
	// Reporting
	// ---------------------------------------------------------------------

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	// ---------------------------------------------------------------------
	// CPU side
	// ---------------------------------------------------------------------

	task automatic apb_access(input logic write, input logic [`CC_ADDR_W-1:0] addr,
		input logic [`CC_DATA_W-1:0] wdata);
		@(posedge clk);
		#DRIVE_DLY;
		psel    = 1'b1;   // Setup phase
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#DRIVE_DLY;
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);   // Miss latency varies
		apb_rdata = prdata;
		@(posedge clk);
		#DRIVE_DLY;
		psel     = 1'b0;
		penable  = 1'b0;
		apb_busy = 1'b0;
	endtask

	task automatic start_apb(input logic write, input logic [`CC_ADDR_W-1:0] addr,
		input logic [`CC_DATA_W-1:0] wdata);
		if (apb_busy) begin
			fail_run("APB transfer started while the previous one is still pending");
		end else begin
			apb_busy = 1'b1;
			fork
				apb_access(write, addr, wdata);
			join_none
		end
	endtask

	task automatic wait_apb();
		while (apb_busy)
			@(negedge clk);
	endtask

	// Core request still waiting and no message out
	task automatic expect_pending();
		@(negedge clk);
		while (apb_busy && !(psel && penable))
			@(negedge clk);   // Until the access phase
		repeat (3) begin
			@(negedge clk);
			check_value("apb_busy", 32'(apb_busy), 32'd1);
			check_value("out_valid", 32'(out_valid), 32'd0);
		end
	endtask

	// ---------------------------------------------------------------------
	// Directory side
	// ---------------------------------------------------------------------

	task automatic send_net(input op_rec_t rec);
		@(posedge clk);
		#DRIVE_DLY;
		in_valid = 1'b1;
		in_type  = cc_pkg::in_msg_t'(rec.f0[2:0]);
		in_line  = rec.f1[`CC_LINE_W-1:0];
		in_aux   = rec.f2[`CC_NODE_W-1:0];   // Ack count or requestor
		in_data  = rec.f3;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk);
		#DRIVE_DLY;
		in_valid = 1'b0;
		in_aux   = '0;
	endtask

	task automatic expect_out(input op_rec_t rec);
		int unsigned stall;
		@(negedge clk);
		while (!out_valid)
			@(negedge clk);
		stall = $urandom % 4;   // 0 to 3 cycles of back-pressure
		repeat (stall)
			@(negedge clk);
		@(posedge clk);
		#DRIVE_DLY;
		out_ready = 1'b1;
		@(negedge clk);
		check_value("out_valid", 32'(out_valid), 32'd1);
		check_value("out_type", 32'(out_type), rec.f0);
		check_value("out_line", 32'(out_line), rec.f1);
		check_value("out_dest_dir", 32'(out_dest_dir), rec.f2);
		check_value("out_dest_req", 32'(out_dest_req), rec.f3);
		check_value("out_node", 32'(out_node), rec.f4);
		check_value("out_data", out_data, rec.f5);
		@(posedge clk);   // Transfer edge
		#DRIVE_DLY;
		out_ready = 1'b0;
	endtask

	// ---------------------------------------------------------------------
	// Test data
	// ---------------------------------------------------------------------

	task automatic load_ops();
		int          fd;
		string       line_str;
		logic [7:0]  op;
		logic [31:0] f0, f1, f2, f3, f4, f5;
		op_rec_t     rec;
		fd = $fopen("verif/cc_testdata.txt", "r");
		if (fd == 0) begin
			fail_run("Could not open the test data file verif/cc_testdata.txt");
		end else begin
			while (!$feof(fd)) begin
				line_str = "";
				if ($fgets(line_str, fd) > 1 && line_str[0] != "#") begin
					f0 = '0;
					f1 = '0;
					f2 = '0;
					f3 = '0;
					f4 = '0;
					f5 = '0;
					void'($sscanf(line_str, "%c %h %h %h %h %h %h",
						op, f0, f1, f2, f3, f4, f5));
					rec = '{op, f0, f1, f2, f3, f4, f5};
					ops.push_back(rec);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_op(input op_rec_t rec);
		case (rec.op)
			"L": start_apb(1'b0, rec.f0[`CC_ADDR_W-1:0], '0);
			"S": start_apb(1'b1, rec.f0[`CC_ADDR_W-1:0], rec.f1);
			"E": start_apb(1'b1, rec.f0[`CC_ADDR_W-1:0], '0);   // Evict window address
			"R": begin
				wait_apb();
				check_value("prdata", apb_rdata, rec.f0);
			end
			"D": wait_apb();
			"N": send_net(rec);
			"O": expect_out(rec);
			"P": expect_pending();
			default: fail_run($sformatf("Unknown operation %c in the test data", rec.op));
		endcase
	endtask

	// ---------------------------------------------------------------------
	// Main sequence
	// ---------------------------------------------------------------------

	initial begin
		void'($urandom(32'h9a71));
		rst       = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		in_valid  = 1'b0;
		in_type   = cc_pkg::INV;
		in_line   = '0;
		in_aux    = '0;
		in_data   = '0;
		out_ready = 1'b0;
		apb_busy  = 1'b0;
		apb_rdata = '0;
		load_ops();
		watchdog_ns = ops.size() * OP_NS + 40 * 20;   // Plus reset and drain
		repeat (3)
			@(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		foreach (ops[i])
			run_op(ops[i]);
		wait_apb();
		repeat (4)
			@(negedge clk);
		check_value("out_valid", 32'(out_valid), 32'd0);   // No stray message
		if (i_dut.i_asserts.fail_count != 0) begin
			fail_run("A protocol assertion failed during the run");
		end else begin
			$display("No errors");
			$finish;
		end
	end

	// Bound protocol checker
	always @(negedge clk) begin
		if (i_dut.i_asserts.fail_count != 0)
			fail_run("A protocol assertion failed, see the message above");
	end

	initial begin
		wait (watchdog_ns != 0);
		#(watchdog_ns);
		fail_run($sformatf("Timeout, operations not finished after %0d ns", watchdog_ns));
	end

endmodule

// File: verif/cc_testdata.txt
# L|S|E addr [wdata]: start APB load, store, evict   R rdata: wait and check   D: wait   P: pending
# N type line aux data: inbound message   O type line dir req node data: expected outbound
# Load miss from I, then a hit
L 00
O 0 0 1 0 0 00000000
N 4 0 0 11110000
R 11110000
L 00
R 11110000
# Store miss, two acks after the data
S 04 aaaa0001
O 1 1 1 0 0 00000000
P
N 4 1 2 dddd0001
P
N 6 1 0 00000000
P
N 6 1 0 00000000
D
L 04
R aaaa0001
# Store miss, acks before the data
S 0c bbbb0003
O 1 3 1 0 0 00000000
N 6 3 0 00000000
N 6 3 0 00000000
N 4 3 2 dddd0003
D
L 0c
R bbbb0003
# Upgrade from S with one ack
S 00 cccc0000
O 1 0 1 0 0 00000000
N 4 0 1 eeee0000
P
N 6 0 0 00000000
D
L 00
R cccc0000
# Fwd_GetS on M, then the store misses again
N 1 1 5 00000000
O 5 1 1 1 5 aaaa0001
S 04 aaaa1111
O 1 1 1 0 0 00000000
N 4 1 0 00000000
D
# Fwd_GetM on M, then the load misses
N 2 3 7 00000000
O 5 3 0 1 7 bbbb0003
L 0c
O 0 3 1 0 0 00000000
N 5 3 0 cafe0003
R cafe0003
# Evict M, Fwd_GetS in MIa, Put_Ack
E 14
O 3 1 1 0 0 aaaa1111
D
N 1 1 9 00000000
O 5 1 1 1 9 aaaa1111
N 3 1 0 00000000
# Evict S, Inv in SIa, next miss waits for Put_Ack
E 1c
O 2 3 1 0 0 00000000
D
N 0 3 6 00000000
O 4 3 0 1 6 00000000
L 08
P
N 3 3 0 00000000
O 0 2 1 0 0 00000000
N 4 2 0 12345678
R 12345678

// File: sim.f
+incdir+hw
hw/cc_pkg.sv
hw/cc_ctrl_if.sv
hw/cc_protocol_fsm.sv
hw/cc_ack_counter.sv
hw/cc_line_store.sv
hw/cc_msg_out.sv
hw/cc_top.sv
verif/cc_asserts.sv
verif/cc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the coherence controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build

verilator --binary --timing --assert -j 0 --top-module cc_tb \
	-f sim.f --Mdir "$BUILD_DIR" -o cc_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Build failed with status $status"
	exit "$status"
fi

# Assertion errors are counted by the testbench, which ends the run
"$BUILD_DIR/cc_sim" +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi
echo "Simulation passed"
exit 0
